// File: rtl/invaders_pkg.sv
`default_nettype none

package invaders_pkg;

    // ------------------------------
    // Coordinates and bundles
    // ------------------------------
    localparam int COORD_W = 10;             // Every screen coordinate

    typedef struct packed {
        logic [COORD_W-1:0] x;               // Column
        logic [COORD_W-1:0] y;               // Row
    } pixel_pos_t;

    typedef struct packed {
        logic hsync;                         // Active low
        logic vsync;                         // Active low
        logic blank_n;                       // High in visible area
    } sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // ------------------------------
    // Sprite boxes
    // ------------------------------
    localparam logic [COORD_W-1:0] PLAYER_W  = 10'd8;
    localparam logic [COORD_W-1:0] PLAYER_H  = 10'd4;
    localparam logic [COORD_W-1:0] MISSILE_W = 10'd1;
    localparam logic [COORD_W-1:0] MISSILE_H = 10'd3;
    localparam logic [COORD_W-1:0] ALIEN_W   = 10'd6;
    localparam logic [COORD_W-1:0] ALIEN_H   = 10'd4;

    // Fixed rows, low enough to fit a 48 line screen
    localparam logic [COORD_W-1:0] PLAYER_Y = 10'd40;
    localparam logic [COORD_W-1:0] ALIEN_Y  = 10'd8;

    // Pixels per frame
    localparam logic [COORD_W-1:0] PLAYER_STEP  = 10'd2;
    localparam logic [COORD_W-1:0] MISSILE_STEP = 10'd4;
    localparam logic [COORD_W-1:0] ALIEN_STEP   = 10'd1;

    // USB HID usage codes
    localparam logic [7:0] KEY_LEFT  = 8'h04;     // 'A'
    localparam logic [7:0] KEY_RIGHT = 8'h07;     // 'D'

    localparam rgb_t COL_BG      = '{r: 8'h00, g: 8'h00, b: 8'h30};   // Dark navy
    localparam rgb_t COL_PLAYER  = '{r: 8'h00, g: 8'hff, b: 8'h00};
    localparam rgb_t COL_MISSILE = '{r: 8'hff, g: 8'hff, b: 8'hff};
    localparam rgb_t COL_ALIEN   = '{r: 8'hff, g: 8'h20, b: 8'h20};

endpackage

`default_nettype wire

// File: rtl/vga_timing.sv
`default_nettype none
`timescale 1ns/10ps

module vga_timing
    import invaders_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire logic Clk,
    input  wire logic rst_n,
    output pixel_pos_t raster,
    output sync_t      raster_sync,
    output logic       frame_tick
);

    // ------------------------------
    // Line and frame landmarks
    // ------------------------------
    localparam logic [COORD_W-1:0] H_VIS_END  = COORD_W'(H_ACTIVE);
    localparam logic [COORD_W-1:0] H_SYNC_BEG = COORD_W'(H_ACTIVE + H_FRONT);
    localparam logic [COORD_W-1:0] H_SYNC_END = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [COORD_W-1:0] H_LAST     = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [COORD_W-1:0] V_VIS_END  = COORD_W'(V_ACTIVE);
    localparam logic [COORD_W-1:0] V_SYNC_BEG = COORD_W'(V_ACTIVE + V_FRONT);
    localparam logic [COORD_W-1:0] V_SYNC_END = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam logic [COORD_W-1:0] V_LAST     = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    logic [COORD_W-1:0] h_cnt;   // Pixel within line
    logic [COORD_W-1:0] v_cnt;   // Line within frame

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;   // Wrap at frame end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Decode straight from the counters so sync lines up with raster
    always_comb begin
        raster.x            = h_cnt;
        raster.y            = v_cnt;
        raster_sync.hsync   = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
        raster_sync.vsync   = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));
        raster_sync.blank_n = (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);
    end

    // First pixel of first front porch line
    assign frame_tick = (h_cnt == '0) && (v_cnt == V_VIS_END);

endmodule

`default_nettype wire

// File: rtl/player_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module player_ctrl
    import invaders_pkg::*;
#(
    parameter int H_ACTIVE = 640          // Screen width
) (
    input  wire logic       Clk,
    input  wire logic       rst_n,
    input  wire logic       frame_tick,
    input  wire logic [7:0] keycode,
    output pixel_pos_t      player_pos
);

    // Rightmost legal x and the centred start
    localparam logic [COORD_W-1:0] X_MAX   = COORD_W'(H_ACTIVE) - PLAYER_W;
    localparam logic [COORD_W-1:0] X_START = COORD_W'((H_ACTIVE - int'(PLAYER_W)) / 2);

    logic [COORD_W-1:0] x_q;
    logic [COORD_W-1:0] x_next;

    // ------------------------------
    // Next position from key
    // ------------------------------
    always_comb begin
        x_next = x_q;                                 // Any other key holds
        case (keycode)
            KEY_LEFT: begin
                if (x_q < PLAYER_STEP) begin
                    x_next = '0;                      // Clamp at left edge
                end else begin
                    x_next = x_q - PLAYER_STEP;
                end
            end
            KEY_RIGHT: begin
                if (x_q >= X_MAX - PLAYER_STEP) begin
                    x_next = X_MAX;                   // Clamp at right edge
                end else begin
                    x_next = x_q + PLAYER_STEP;
                end
            end
            default: x_next = x_q;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q <= X_START;
        end else if (frame_tick) begin
            x_q <= x_next;                            // Once per frame
        end
    end

    assign player_pos = '{x: x_q, y: PLAYER_Y};       // Row never changes

endmodule

`default_nettype wire

// File: rtl/missile_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module missile_ctrl
    import invaders_pkg::*;
(
    input  wire logic Clk,
    input  wire logic rst_n,
    input  wire logic frame_tick,
    input  wire logic shoot,
    input  pixel_pos_t player_pos,
    input  pixel_pos_t alien_pos,
    output pixel_pos_t missile_pos,
    output logic       missile_active,
    output logic       hit
);

    pixel_pos_t pos_q;
    logic       active_q;
    logic       overlap;

    // Box ends, one bit wider to avoid wrap near the counter top
    logic [COORD_W:0] m_x_end;
    logic [COORD_W:0] m_y_end;
    logic [COORD_W:0] a_x_end;
    logic [COORD_W:0] a_y_end;

    // ------------------------------
    // Missile vs alien overlap
    // ------------------------------
    always_comb begin
        m_x_end = {1'b0, pos_q.x} + {1'b0, MISSILE_W};
        m_y_end = {1'b0, pos_q.y} + {1'b0, MISSILE_H};
        a_x_end = {1'b0, alien_pos.x} + {1'b0, ALIEN_W};
        a_y_end = {1'b0, alien_pos.y} + {1'b0, ALIEN_H};
        overlap = ({1'b0, pos_q.x} < a_x_end) && ({1'b0, alien_pos.x} < m_x_end)
               && ({1'b0, pos_q.y} < a_y_end) && ({1'b0, alien_pos.y} < m_y_end);
    end

    // Same cycle as the tick so the alien reacts on the same edge
    assign hit = frame_tick && active_q && overlap;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            pos_q    <= '0;
        end else if (frame_tick) begin
            if (active_q && overlap) begin
                active_q <= 1'b0;                        // Consumed by the hit
            end else if (active_q) begin
                if (pos_q.y < MISSILE_STEP) begin
                    active_q <= 1'b0;                    // Off the top
                end else begin
                    pos_q.y <= pos_q.y - MISSILE_STEP;   // x stays fixed in flight
                end
            end else if (shoot) begin
                active_q <= 1'b1;
                pos_q.x  <= player_pos.x + PLAYER_W / 2; // Cannon muzzle
                pos_q.y  <= PLAYER_Y - MISSILE_H;
            end
        end
    end

    assign missile_pos    = pos_q;
    assign missile_active = active_q;

endmodule

`default_nettype wire

// File: rtl/alien_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module alien_ctrl
    import invaders_pkg::*;
#(
    parameter int H_ACTIVE = 640          // Screen width
) (
    input  wire logic       Clk,
    input  wire logic       rst_n,
    input  wire logic       frame_tick,
    input  wire logic       hit,
    output pixel_pos_t      alien_pos,
    output logic [7:0]      score
);

    localparam logic [COORD_W-1:0] X_MAX = COORD_W'(H_ACTIVE) - ALIEN_W;

    logic [COORD_W-1:0] x_q;
    logic               right_q;     // 1 moving right
    logic [7:0]         score_q;

    // ------------------------------
    // Sweep and respawn
    // ------------------------------
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q     <= '0;
            right_q <= 1'b1;
            score_q <= '0;
        end else if (hit) begin
            x_q     <= '0;                       // Back to left edge
            right_q <= 1'b1;
            score_q <= score_q + 1'b1;           // Wraps at 255
        end else if (frame_tick) begin
            if (right_q) begin
                if (x_q > X_MAX - ALIEN_STEP) begin
                    right_q <= 1'b0;             // Turn without stepping
                end else begin
                    x_q <= x_q + ALIEN_STEP;
                end
            end else begin
                if (x_q < ALIEN_STEP) begin
                    right_q <= 1'b1;
                end else begin
                    x_q <= x_q - ALIEN_STEP;
                end
            end
        end
    end

    // Hit only ever comes with a tick so it takes priority over the step

    assign alien_pos = '{x: x_q, y: ALIEN_Y};
    assign score     = score_q;

endmodule

`default_nettype wire

// File: rtl/pixel_mixer.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_mixer
    import invaders_pkg::*;
(
    input  wire logic Clk,
    input  wire logic rst_n,
    input  pixel_pos_t raster,
    input  sync_t      raster_sync,
    input  pixel_pos_t player_pos,
    input  pixel_pos_t missile_pos,
    input  wire logic  missile_active,
    input  pixel_pos_t alien_pos,
    output sync_t      video_sync,
    output rgb_t       video_rgb
);

    // Pixel p inside box at b of size w by h
    function automatic logic in_box(pixel_pos_t p, pixel_pos_t b,
                                    logic [COORD_W-1:0] w, logic [COORD_W-1:0] h);
        logic [COORD_W:0] x_end;
        logic [COORD_W:0] y_end;
        x_end = {1'b0, b.x} + {1'b0, w};
        y_end = {1'b0, b.y} + {1'b0, h};
        return (p.x >= b.x) && ({1'b0, p.x} < x_end)
            && (p.y >= b.y) && ({1'b0, p.y} < y_end);
    endfunction

    logic is_player;
    logic is_missile;
    logic is_alien;
    rgb_t colour;

    // ------------------------------
    // Object hit test and priority
    // ------------------------------
    always_comb begin
        is_missile = missile_active && in_box(raster, missile_pos, MISSILE_W, MISSILE_H);
        is_player  = in_box(raster, player_pos, PLAYER_W, PLAYER_H);
        is_alien   = in_box(raster, alien_pos, ALIEN_W, ALIEN_H);
        if (!raster_sync.blank_n) colour = '0;        // Black in blanking
        else if (is_missile)      colour = COL_MISSILE;
        else if (is_player)       colour = COL_PLAYER;
        else if (is_alien)        colour = COL_ALIEN;
        else                      colour = COL_BG;
    end

    // Sync and colour share one stage
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            video_sync <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
            video_rgb  <= '0;
        end else begin
            video_sync <= raster_sync;
            video_rgb  <= colour;
        end
    end

endmodule

`default_nettype wire

// File: rtl/invaders_top.sv
`default_nettype none
`timescale 1ns/10ps

module invaders_top
    import invaders_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire logic       Clk,         // Pixel clock
    input  wire logic       rst_n,
    input  wire logic [7:0] keycode,     // Held key level
    input  wire logic       shoot,
    output sync_t           video_sync,
    output rgb_t            video_rgb,
    output logic [7:0]      score
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    pixel_pos_t raster;
    sync_t      raster_sync;
    logic       frame_tick;   // One pulse per frame
    pixel_pos_t player_pos;
    pixel_pos_t missile_pos;
    pixel_pos_t alien_pos;
    logic       missile_active;
    logic       hit;          // Missile struck alien

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .Clk, .rst_n, .raster, .raster_sync, .frame_tick
    );

    player_ctrl #(.H_ACTIVE(H_ACTIVE)) u_player_ctrl (
        .Clk, .rst_n, .frame_tick, .keycode, .player_pos
    );

    missile_ctrl u_missile_ctrl (
        .Clk, .rst_n, .frame_tick, .shoot, .player_pos, .alien_pos,
        .missile_pos, .missile_active, .hit
    );

    alien_ctrl #(.H_ACTIVE(H_ACTIVE)) u_alien_ctrl (
        .Clk, .rst_n, .frame_tick, .hit, .alien_pos, .score
    );

    // Output stage
    pixel_mixer u_pixel_mixer (
        .Clk, .rst_n, .raster, .raster_sync, .player_pos, .missile_pos,
        .missile_active, .alien_pos, .video_sync, .video_rgb
    );

endmodule

`default_nettype wire

// File: verification/invaders_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module invaders_assertions
    import invaders_pkg::*;
#(
    parameter bit CHECK_VIDEO = 1'b1      // 1 video side, 0 missile side
) (
    input  wire logic       Clk,
    input  wire logic       rst_n,
    input  wire sync_t      video_sync,
    input  wire rgb_t       video_rgb,
    input  wire logic       missile_active,
    input  wire pixel_pos_t missile_pos,
    input  wire logic       hit
);

    generate
        if (CHECK_VIDEO) begin : g_video
            // Blanked pixels carry no colour
            a_blank_black: assert property (@(posedge Clk) disable iff (!rst_n)
                !video_sync.blank_n |-> (video_rgb == '0))
                else $error("video_rgb not black during blanking");
        end else begin : g_missile
            // Hit needs a live missile and consumes it
            a_hit_clears: assert property (@(posedge Clk) disable iff (!rst_n)
                hit |=> ($past(missile_active) && !missile_active))
                else $error("hit without an active missile or missile not cleared");

            // Column fixed from launch until cleared
            a_x_steady: assert property (@(posedge Clk) disable iff (!rst_n)
                (missile_active && $past(missile_active))
                    |-> (missile_pos.x == $past(missile_pos.x)))
                else $error("missile x moved in flight");
        end
    endgenerate

endmodule

// Mixer side checks the output colour only
bind pixel_mixer invaders_assertions #(.CHECK_VIDEO(1'b1)) u_mixer_checks (
    .Clk, .rst_n, .video_sync, .video_rgb, .missile_active, .missile_pos, .hit(1'b0)
);

// Missile side checks flight and hit only
bind missile_ctrl invaders_assertions #(.CHECK_VIDEO(1'b0)) u_missile_checks (
    .Clk, .rst_n, .video_sync(3'b110), .video_rgb(24'h0), .missile_active, .missile_pos, .hit
);

`default_nettype wire

// File: verification/tb_invaders.sv
`default_nettype none
`timescale 1ns/10ps

module tb_invaders
    import invaders_pkg::*;
();

    // ------------------------------
    // Small screen and run length
    // ------------------------------
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 6;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RUN_FRAMES   = 200;
    localparam int LEFT_FRAMES  = 24;           // Cannon walks to the left wall
    localparam int RIGHT_FRAMES = 64;           // Then to the right wall
    localparam int SWEEP_FRAMES = 124;          // Alien turns at both edges first
    localparam int RESET_CYCLES = 16;

    logic       Clk;
    logic       rst_n;
    logic [7:0] keycode;
    logic       shoot;
    sync_t      video_sync;
    rgb_t       video_rgb;
    logic [7:0] score;

    integer     seed;
    logic       checking;                       // Model running
    event       frame_evt;
    int         frames;
    int         h_m;                            // Model raster
    int         v_m;
    int         p_x;                            // Model game state
    int         m_x;
    int         m_y;
    int         a_x;
    logic       m_act;
    logic       a_right;
    logic [7:0] sc;
    sync_t      exp_sync;                       // Due after the current edge
    rgb_t       exp_rgb;

    invaders_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_invaders_top (
        .Clk, .rst_n, .keycode, .shoot, .video_sync, .video_rgb, .score
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    function automatic logic inside_box(int px, int py, int bx, int by, int w, int h);
        return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
    endfunction

    function automatic sync_t sync_at(int h, int v);
        sync_t s;
        s.hsync   = !((h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC));
        s.vsync   = !((v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC));
        s.blank_n = (h < H_ACTIVE) && (v < V_ACTIVE);
        return s;
    endfunction

    // Missile over player over alien over background
    function automatic rgb_t colour_at(int h, int v);
        if ((h >= H_ACTIVE) || (v >= V_ACTIVE)) return '0;
        if (m_act && inside_box(h, v, m_x, m_y, int'(MISSILE_W), int'(MISSILE_H)))
            return COL_MISSILE;
        if (inside_box(h, v, p_x, int'(PLAYER_Y), int'(PLAYER_W), int'(PLAYER_H)))
            return COL_PLAYER;
        if (inside_box(h, v, a_x, int'(ALIEN_Y), int'(ALIEN_W), int'(ALIEN_H)))
            return COL_ALIEN;
        return COL_BG;
    endfunction

    // ------------------------------
    // Game rules, one frame step
    // ------------------------------
    task automatic step_game();
        logic hit_now;
        int   old_p_x;
        old_p_x = p_x;                                   // Launch uses the old cannon
        hit_now = m_act && (m_x < a_x + int'(ALIEN_W)) && (a_x < m_x + int'(MISSILE_W))
               && (m_y < int'(ALIEN_Y) + int'(ALIEN_H))
               && (int'(ALIEN_Y) < m_y + int'(MISSILE_H));
        if (keycode == KEY_LEFT) begin
            p_x = p_x - int'(PLAYER_STEP);
            if (p_x < 0) p_x = 0;                        // Left wall
        end else if (keycode == KEY_RIGHT) begin
            p_x = p_x + int'(PLAYER_STEP);
            if (p_x > H_ACTIVE - int'(PLAYER_W)) p_x = H_ACTIVE - int'(PLAYER_W);
        end
        if (hit_now) begin
            m_act = 1'b0;
        end else if (m_act) begin
            m_y = m_y - int'(MISSILE_STEP);
            if (m_y < 0) m_act = 1'b0;                   // Gone past the top
        end else if (shoot) begin
            m_act = 1'b1;
            m_x   = old_p_x + int'(PLAYER_W) / 2;
            m_y   = int'(PLAYER_Y) - int'(MISSILE_H);
        end
        if (hit_now) begin
            a_x     = 0;                                 // Respawn at left, heading right
            a_right = 1'b1;
            sc      = sc + 8'd1;
        end else if (a_right) begin
            if (a_x + int'(ALIEN_STEP) > H_ACTIVE - int'(ALIEN_W)) a_right = 1'b0;
            else a_x += int'(ALIEN_STEP);
        end else begin
            if (a_x - int'(ALIEN_STEP) < 0) a_right = 1'b1;
            else a_x -= int'(ALIEN_STEP);
        end
    endtask

    always @(posedge Clk) begin
        if (checking) begin
            exp_sync = sync_at(h_m, v_m);                // Output lags raster by one Clk
            exp_rgb  = colour_at(h_m, v_m);
            if ((h_m == 0) && (v_m == V_ACTIVE)) begin   // Model frame tick
                step_game();
                frames = frames + 1;
                -> frame_evt;
            end
            if (h_m == H_TOTAL - 1) begin
                h_m = 0;
                v_m = (v_m == V_TOTAL - 1) ? 0 : v_m + 1;
            end else begin
                h_m = h_m + 1;
            end
        end
    end

    // ------------------------------
    // Compare and stop
    // ------------------------------
    task automatic stop_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, why);
    endtask

    task automatic check_sync(input sync_t got, input sync_t want);
        if (got !== want) begin
            $display("Fail video_sync got %h expected %h", got, want);
            stop_run("video_sync mismatch");
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t want);
        if (got !== want) begin
            $display("Fail video_rgb got %h expected %h", got, want);
            stop_run("video_rgb mismatch");
        end
    endtask

    task automatic check_score(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("Fail score got %h expected %h", got, want);
            stop_run("score mismatch");
        end
    endtask

    always @(negedge Clk) begin
        if (checking) begin
            check_sync(video_sync, exp_sync);
            check_rgb(video_rgb, exp_rgb);
            check_score(score, sc);
        end
    end

    // Walls first while the alien sweeps, then shooting at it
    task automatic drive_inputs();
        int         pick;
        int         aim;
        logic [7:0] other;
        pick  = {$random(seed)} % 8;
        other = 8'($random(seed));
        if ((other == KEY_LEFT) || (other == KEY_RIGHT)) other = 8'h00;
        if (frames < SWEEP_FRAMES) begin
            shoot = 1'b0;                                // No hits during the sweep
            if (frames < LEFT_FRAMES) keycode = (pick < 7) ? KEY_LEFT : other;
            else if (frames < RIGHT_FRAMES) keycode = (pick < 7) ? KEY_RIGHT : other;
            else if (pick < 3) keycode = KEY_LEFT;
            else if (pick < 6) keycode = KEY_RIGHT;
            else keycode = other;
        end else begin
            // Lead the alien by its travel while a missile climbs to it
            aim   = a_x + 2 + (a_right ? 8 : -8) - int'(PLAYER_W) / 2;
            shoot = ({$random(seed)} % 8) != 0;          // Mostly held
            if (pick == 7) keycode = other;
            else if (p_x < aim) keycode = KEY_RIGHT;
            else if (p_x > aim) keycode = KEY_LEFT;
            else keycode = other;
        end
    endtask

    initial begin
        repeat (RESET_CYCLES + (RUN_FRAMES + 5) * FRAME_CYCLES) @(posedge Clk);
        $display("Watchdog expired before the run finished");
        stop_run("watchdog timeout");
    end

    initial begin
        seed     = 32'h9b7b;
        rst_n    = 1'b0;
        keycode  = 8'h00;
        shoot    = 1'b0;
        checking = 1'b0;
        frames   = 0;
        h_m      = 0;
        v_m      = 0;
        p_x      = (H_ACTIVE - int'(PLAYER_W)) / 2;      // Centred cannon
        m_x      = 0;
        m_y      = 0;
        m_act    = 1'b0;
        a_x      = 0;
        a_right  = 1'b1;
        sc       = 8'h00;
        exp_sync = '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
        exp_rgb  = '0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #2;
        rst_n    = 1'b1;
        checking = 1'b1;
        drive_inputs();
        while (frames < RUN_FRAMES) begin
            @(frame_evt);
            #2;
            drive_inputs();                              // New levels for the next frame
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/invaders_pkg.sv
rtl/vga_timing.sv
rtl/player_ctrl.sv
rtl/missile_ctrl.sv
rtl/alien_ctrl.sv
rtl/pixel_mixer.sv
rtl/invaders_top.sv
verification/invaders_assertions.sv
verification/tb_invaders.sv

// File: run.sh
#!/bin/sh
# Build and run the invaders testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_invaders -f all.f --Mdir obj_dir -o sim_invaders
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_invaders
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi
exit 0
